// File: all.f
source/aembPkg.sv
source/pipeStage.sv
source/instrDecode.sv
source/intExecute.sv
source/regWriteback.sv
source/aembCore.sv
verification/clockGen.sv
verification/aembCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

verilator --binary -j 0 --top-module aembCoreTb -f all.f -o aembCoreSim

out=$(./obj_dir/aembCoreSim)
echo "$out"
# Exit status follows the search for the pass line
echo "$out" | grep -qx "sim passed"

// File: source/aembCore.sv
`timescale 1ns/100ps
`default_nettype none

module aembCore (
	input wire nclk,
	input wire nrst,

	input wire instrValid_i,
	output logic instrReady_o,
	input wire aembPkg::wordT instrWord_i,

	output logic resValid_o,
	input wire resReady_i,
	output logic resIsBranch_o,
	output aembPkg::regIdxT resRd_o,
	output aembPkg::wordT resData_o,
	output logic resTaken_o
);

	import aembPkg::*;

	// Decode to first stage
	wire decValid;
	wire decReady;
	wire decOpT decOp;

	// First stage to execute
	wire stgValid;
	wire stgReady;
	wire decOpT stgOp;

	// Execute to second stage
	wire exValid;
	wire exReady;
	wire resultT exRes;

	// Second stage head, also the forwarding source
	wire pendValid;
	wire pendReady;
	wire resultT pendRes;

	// Register file read ports
	wire regIdxT rdAddrA;
	wire regIdxT rdAddrB;
	wire wordT rdDataA;
	wire wordT rdDataB;

	instrDecode u_decode (
		.nclk(nclk), .nrst(nrst),
		.instrValid_i(instrValid_i), .instrReady_o(instrReady_o), .instrWord_i(instrWord_i),
		.decValid_o(decValid), .decReady_i(decReady), .decOp_o(decOp)
	);

	pipeStage #(.payloadT(decOpT)) u_decStage (
		.nclk(nclk), .nrst(nrst),
		.inValid_i(decValid), .inReady_o(decReady), .inData_i(decOp),
		.outValid_o(stgValid), .outReady_i(stgReady), .outData_o(stgOp)
	);

	intExecute u_execute (
		.decValid_i(stgValid), .decReady_o(stgReady), .decOp_i(stgOp),
		.rdAddrA_o(rdAddrA), .rdAddrB_o(rdAddrB), .rdDataA_i(rdDataA), .rdDataB_i(rdDataB),
		.pendValid_i(pendValid), .pendRes_i(pendRes),
		.exValid_o(exValid), .exReady_i(exReady), .exRes_o(exRes)
	);

	pipeStage #(.payloadT(resultT)) u_exStage (
		.nclk(nclk), .nrst(nrst),
		.inValid_i(exValid), .inReady_o(exReady), .inData_i(exRes),
		.outValid_o(pendValid), .outReady_i(pendReady), .outData_o(pendRes)
	);

	regWriteback u_writeback (
		.nclk(nclk), .nrst(nrst),
		.exValid_i(pendValid), .exReady_o(pendReady), .exRes_i(pendRes),
		.rdAddrA_i(rdAddrA), .rdAddrB_i(rdAddrB), .rdDataA_o(rdDataA), .rdDataB_o(rdDataB),
		.resValid_o(resValid_o), .resReady_i(resReady_i), .resIsBranch_o(resIsBranch_o),
		.resRd_o(resRd_o), .resData_o(resData_o), .resTaken_o(resTaken_o)
	);

endmodule

`default_nettype wire

// File: source/aembPkg.sv
`default_nettype none

package aembPkg;

	typedef logic [4:0] regIdxT; // Register index
	typedef logic [31:0] wordT; // Data and instruction word

	// Major opcodes, register forms unless noted
	localparam logic [5:0] opAdd = 6'h00;
	localparam logic [5:0] opRsub = 6'h01;
	localparam logic [5:0] opOr = 6'h20;
	localparam logic [5:0] opAnd = 6'h21;
	localparam logic [5:0] opXor = 6'h22;
	localparam logic [5:0] opAndn = 6'h23;
	localparam logic [5:0] opShift = 6'h24; // Type picked by low half
	localparam logic [5:0] opBcc = 6'h27;
	localparam logic [5:0] opBcci = 6'h2F; // Branch, immediate target
	localparam logic [5:0] opImm = 6'h2C; // Upper immediate prefix
	localparam logic [5:0] immMask = 6'h08; // OR into base opcode for imm form

	// Instruction field positions, after endian swap
	localparam int opcLsb = 26;
	localparam int rdLsb = 21;
	localparam int raLsb = 16;
	localparam int rbLsb = 11;
	localparam int immLsb = 0;
	localparam int immSelBit = 3; // Opcode bit for immediate operand

	// Shift selectors in imm16
	localparam logic [15:0] shiftSra = 16'h0001;
	localparam logic [15:0] shiftSrl = 16'h0041;

	// Branch conditions, rd bits 2:0
	localparam logic [2:0] condEq = 3'd0;
	localparam logic [2:0] condNe = 3'd1;
	localparam logic [2:0] condLt = 3'd2;
	localparam logic [2:0] condLe = 3'd3;
	localparam logic [2:0] condGt = 3'd4;
	localparam logic [2:0] condGe = 3'd5;

	// Result kinds, value of isBranch
	localparam logic kindAlu = 1'b0;
	localparam logic kindBranch = 1'b1;

	typedef enum logic [3:0] {
		clsAdd, clsRsub, clsOr, clsAnd, clsXor, clsAndn, clsSra, clsSrl, clsBcc
	} opClassT;

	// Decode to execute
	typedef struct packed {
		opClassT cls;
		regIdxT rd;
		regIdxT ra;
		regIdxT rb;
		logic useImm; // Operand B from imm
		wordT imm; // Final 32-bit immediate
	} decOpT;

	// Execute to writeback
	typedef struct packed {
		logic isBranch;
		regIdxT rd;
		wordT data; // ALU value or branch offset
		logic taken;
	} resultT;

endpackage

`default_nettype wire

// File: source/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
	input wire nclk,
	input wire nrst,

	input wire instrValid_i,
	output logic instrReady_o,
	input wire aembPkg::wordT instrWord_i,

	output logic decValid_o,
	input wire decReady_i,
	output aembPkg::decOpT decOp_o
);

	import aembPkg::*;

	wordT swWord; // Endian corrected word
	logic [5:0] opc;
	regIdxT rd;
	regIdxT ra;
	regIdxT rb;
	logic [15:0] imm16;

	opClassT opClass;
	logic known; // Supported non-prefix opcode
	logic isImm;
	logic accept;

	logic [15:0] immHi; // Upper half from last IMM
	logic immPend; // IMM seen, next op takes immHi
	wordT fullImm;

	// Byte swap, bus order to instruction order
	assign swWord = {instrWord_i[7:0], instrWord_i[15:8],
		instrWord_i[23:16], instrWord_i[31:24]};

	// Fields
	assign opc = swWord[opcLsb +: 6];
	assign rd = swWord[rdLsb +: 5];
	assign ra = swWord[raLsb +: 5];
	assign rb = swWord[rbLsb +: 5];
	assign imm16 = swWord[immLsb +: 16];

	assign isImm = (opc == opImm);

	// Opcode to class, imm forms share the class
	always_comb begin
		opClass = clsAdd;
		known = 1'b1;
		case (opc)
			opAdd, opAdd | immMask: opClass = clsAdd;
			opRsub, opRsub | immMask: opClass = clsRsub;
			opOr, opOr | immMask: opClass = clsOr;
			opAnd, opAnd | immMask: opClass = clsAnd;
			opXor, opXor | immMask: opClass = clsXor;
			opAndn, opAndn | immMask: opClass = clsAndn;
			opShift: begin
				if (imm16 == shiftSra) begin
					opClass = clsSra;
				end else if (imm16 == shiftSrl) begin
					opClass = clsSrl;
				end else begin
					known = 1'b0; // Other shift types not built
				end
			end
			opBcc, opBcci: opClass = clsBcc;
			default: known = 1'b0; // IMM lands here too
		endcase
	end

	// Prefix joins or plain sign extension
	assign fullImm = immPend ? {immHi, imm16} : {{16{imm16[15]}}, imm16};

	// Consumed ops never reach the stage, so ready is shared
	assign instrReady_o = decReady_i;
	assign accept = instrValid_i && decReady_i;
	assign decValid_o = instrValid_i && known;

	always_comb begin
		decOp_o.cls = opClass;
		decOp_o.rd = rd;
		decOp_o.ra = ra;
		decOp_o.rb = rb;
		decOp_o.useImm = opc[immSelBit];
		decOp_o.imm = fullImm;
	end

	// IMM latch, moves only on a transfer
	always_ff @(posedge nclk) begin
		if (!nrst) begin
			immPend <= 1'b0;
			immHi <= '0;
		end else if (accept) begin
			immPend <= isImm; // Any other op uses it up
			if (isImm) begin
				immHi <= imm16;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/intExecute.sv
`timescale 1ns/100ps
`default_nettype none

module intExecute (
	input wire decValid_i,
	output logic decReady_o,
	input wire aembPkg::decOpT decOp_i,

	output aembPkg::regIdxT rdAddrA_o,
	output aembPkg::regIdxT rdAddrB_o,
	input wire aembPkg::wordT rdDataA_i,
	input wire aembPkg::wordT rdDataB_i,

	input wire pendValid_i,
	input wire aembPkg::resultT pendRes_i,

	output logic exValid_o,
	input wire exReady_i,
	output aembPkg::resultT exRes_o
);

	import aembPkg::*;

	logic fwdOk; // Pending record will write a register
	wordT opA;
	wordT regB;
	wordT opB;
	wordT aluVal;
	logic isBcc;

	logic bEq;
	logic bLt;
	logic bLe;
	logic taken;

	// Register file addresses straight from the op
	assign rdAddrA_o = decOp_i.ra;
	assign rdAddrB_o = decOp_i.rb;

	// Forward from the head of the execute stage
	assign fwdOk = pendValid_i && (pendRes_i.isBranch == kindAlu) && (pendRes_i.rd != '0);

	assign opA = (fwdOk && (pendRes_i.rd == decOp_i.ra)) ? pendRes_i.data : rdDataA_i;
	assign regB = (fwdOk && (pendRes_i.rd == decOp_i.rb)) ? pendRes_i.data : rdDataB_i;
	assign opB = decOp_i.useImm ? decOp_i.imm : regB; // Imm form

	assign isBcc = (decOp_i.cls == clsBcc);

	// ALU and shifter
	always_comb begin
		case (decOp_i.cls)
			clsAdd: aluVal = opA + opB;
			clsRsub: aluVal = opB - opA; // Reverse subtract
			clsOr: aluVal = opA | opB;
			clsAnd: aluVal = opA & opB;
			clsXor: aluVal = opA ^ opB;
			clsAndn: aluVal = opA & ~opB;
			clsSra: aluVal = {opA[31], opA[31:1]};
			clsSrl: aluVal = {1'b0, opA[31:1]};
			clsBcc: aluVal = decOp_i.imm; // Target offset passes through
			default: aluVal = '0;
		endcase
	end

	// Comparator, ra against zero
	assign bEq = (opA == '0);
	assign bLt = opA[31];
	assign bLe = bLt || bEq;

	always_comb begin
		case (decOp_i.rd[2:0])
			condEq: taken = bEq;
			condNe: taken = !bEq;
			condLt: taken = bLt;
			condLe: taken = bLe;
			condGt: taken = !bLe;
			condGe: taken = !bLt;
			default: taken = 1'b0; // 6 and 7 never branch
		endcase
	end

	always_comb begin
		exRes_o.isBranch = isBcc ? kindBranch : kindAlu;
		exRes_o.rd = decOp_i.rd;
		exRes_o.data = aluVal;
		exRes_o.taken = isBcc && taken;
	end

	// Single cycle, no state
	assign exValid_o = decValid_i;
	assign decReady_o = exReady_i;

endmodule

`default_nettype wire

// File: source/pipeStage.sv
`timescale 1ns/100ps
`default_nettype none

// One-deep register slice between two valid/ready hops
module pipeStage #(
	parameter type payloadT = logic [31:0]
) (
	input wire nclk,
	input wire nrst,

	input wire inValid_i,
	output logic inReady_o,
	input wire payloadT inData_i,

	output logic outValid_o,
	input wire outReady_i,
	output payloadT outData_o
);

	logic full; // Entry holds live data
	payloadT entry;
	logic load;

	// Accept when empty or draining this cycle
	assign inReady_o = !full || outReady_i;
	assign load = inValid_i && inReady_o;

	always_ff @(posedge nclk) begin
		if (!nrst) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1; // New entry replaces any taken one
		end else if (outReady_i) begin
			full <= 1'b0;
		end
	end

	// Payload only
	always_ff @(posedge nclk) begin
		if (load) begin
			entry <= inData_i;
		end
	end

	assign outValid_o = full;
	assign outData_o = entry;

endmodule

`default_nettype wire

// File: source/regWriteback.sv
`timescale 1ns/100ps
`default_nettype none

module regWriteback (
	input wire nclk,
	input wire nrst,

	input wire exValid_i,
	output logic exReady_o,
	input wire aembPkg::resultT exRes_i,

	input wire aembPkg::regIdxT rdAddrA_i,
	input wire aembPkg::regIdxT rdAddrB_i,
	output aembPkg::wordT rdDataA_o,
	output aembPkg::wordT rdDataB_o,

	output logic resValid_o,
	input wire resReady_i,
	output logic resIsBranch_o,
	output aembPkg::regIdxT resRd_o,
	output aembPkg::wordT resData_o,
	output logic resTaken_o
);

	import aembPkg::*;

	wordT regs [32];
	logic wrEn;

	// Commit on retire handshake, r0 stays zero
	assign wrEn = resValid_o && resReady_i && (exRes_i.isBranch == kindAlu)
		&& (exRes_i.rd != '0);

	always_ff @(posedge nclk) begin
		if (!nrst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[exRes_i.rd] <= exRes_i.data;
		end
	end

	// Async read ports for execute
	assign rdDataA_o = (rdAddrA_i == '0) ? '0 : regs[rdAddrA_i];
	assign rdDataB_o = (rdAddrB_i == '0) ? '0 : regs[rdAddrB_i];

	// Retire stream taken directly from the stage head
	assign resValid_o = exValid_i;
	assign exReady_o = resReady_i;
	assign resIsBranch_o = exRes_i.isBranch;
	assign resRd_o = exRes_i.rd;
	assign resData_o = exRes_i.data;
	assign resTaken_o = exRes_i.taken;

endmodule

`default_nettype wire

// File: verification/aembCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module aembCoreTb;

	import aembPkg::*;

	localparam int nRand = 120;
	localparam int nChain = 60;
	localparam int nImm = 20; // Three instructions each
	localparam int nBranch = 12; // Load plus eight branches
	localparam int nShift = 16; // Load plus two shifts
	localparam int instrCount = nRand + nChain + 3 * nImm + 10 * nBranch + 4 * nShift;
	localparam int cycleLimit = 8 * instrCount + 100;

	logic nclk;
	logic nrst;
	logic instrValid;
	logic instrReady;
	wordT instrWord;
	logic resValid;
	logic resReady;
	logic resIsBranch;
	regIdxT resRd;
	wordT resData;
	logic resTaken;

	wordT modelRegs [32]; // Reference register file
	logic modelImmPend;
	logic [15:0] modelImmHi;
	resultT expQ[$]; // Records in retire order
	string nameQ[$];
	resultT expHead;
	string expName;
	int expCount = 0;
	int gotCount = 0;
	int mismatches = 0;
	int otherErrs = 0; // Monitor side
	int countErr = 0; // End of run side
	int cycles = 0;

	clockGen i_clk (.clk_o(nclk));

	aembCore i_dut (
		.nclk(nclk), .nrst(nrst),
		.instrValid_i(instrValid), .instrReady_o(instrReady), .instrWord_i(instrWord),
		.resValid_o(resValid), .resReady_i(resReady), .resIsBranch_o(resIsBranch),
		.resRd_o(resRd), .resData_o(resData), .resTaken_o(resTaken)
	);

	// Bus carries the low byte first
	function automatic wordT swapBytes(wordT w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic checkWrite(string name, regIdxT expRd, regIdxT actRd, wordT expVal,
		wordT actVal);
		if (expRd !== actRd || expVal !== actVal) begin
			$display("Mismatch %s: expected r%0d = %h, actual r%0d = %h", name, expRd, expVal,
				actRd, actVal);
			mismatches++;
		end
	endtask

	task automatic checkBranch(string name, wordT expTarget, wordT actTarget, logic expTaken,
		logic actTaken);
		if (expTarget !== actTarget || expTaken !== actTaken) begin
			$display("Mismatch %s: expected target %h taken %b, actual target %h taken %b",
				name, expTarget, expTaken, actTarget, actTaken);
			mismatches++;
		end
	endtask

	// ISA rules, one instruction at a time in issue order
	task automatic modelStep(string name, logic [5:0] opc, regIdxT rd, regIdxT ra,
		logic [15:0] low16);
		wordT imm;
		wordT a;
		wordT b;
		resultT r;
		if (opc == opImm) begin
			modelImmPend = 1'b1; // Upper half for the next op
			modelImmHi = low16;
		end else begin
			imm = modelImmPend ? {modelImmHi, low16} : {{16{low16[15]}}, low16};
			modelImmPend = 1'b0;
			a = modelRegs[ra];
			b = opc[3] ? imm : modelRegs[low16[15:11]]; // rb sits in the top bits
			r.isBranch = 1'b0;
			r.rd = rd;
			r.taken = 1'b0;
			if (opc == opBcc || opc == opBcci) begin
				r.isBranch = 1'b1;
				r.data = imm; // Offset only
				case (rd[2:0])
					3'd0: r.taken = (a == '0);
					3'd1: r.taken = (a != '0);
					3'd2: r.taken = ($signed(a) < 0);
					3'd3: r.taken = ($signed(a) <= 0);
					3'd4: r.taken = ($signed(a) > 0);
					3'd5: r.taken = ($signed(a) >= 0);
					default: r.taken = 1'b0;
				endcase
			end else if (opc == opShift) begin
				if (low16 == shiftSra) begin
					r.data = $signed(a) >>> 1;
				end else begin
					r.data = a >> 1;
				end
			end else begin
				case (opc & ~immMask)
					opAdd: r.data = a + b;
					opRsub: r.data = b - a;
					opOr: r.data = a | b;
					opAnd: r.data = a & b;
					opXor: r.data = a ^ b;
					default: r.data = a & ~b; // andn
				endcase
			end
			if (!r.isBranch && rd != '0) begin
				modelRegs[rd] = r.data; // r0 never changes
			end
			expQ.push_back(r);
			nameQ.push_back(name);
			expCount++;
		end
	endtask

	// Entered 1 ns after an edge, leaves the same way
	task automatic issue(string name, logic [5:0] opc, regIdxT rd, regIdxT ra,
		logic [15:0] low16);
		logic rdy;
		modelStep(name, opc, rd, ra, low16);
		instrWord = swapBytes({opc, rd, ra, low16});
		instrValid = 1'b1;
		do begin
			@(negedge nclk);
			rdy = instrReady; // Settled until the edge
			@(posedge nclk);
			#1;
		end while (!rdy);
		instrValid = 1'b0;
		if ($urandom % 5 == 0) begin
			@(posedge nclk); // Occasional bubble
			#1;
		end
	endtask

	task automatic aluImm(string name, logic [5:0] opc, regIdxT rd, regIdxT ra,
		logic [15:0] imm16);
		issue(name, opc | immMask, rd, ra, imm16);
	endtask

	// IMM then addi from r0
	task automatic loadReg(string name, regIdxT r, wordT v);
		issue(name, opImm, 5'd0, 5'd0, v[31:16]);
		aluImm(name, opAdd, r, 5'd0, v[15:0]);
	endtask

	function automatic logic [5:0] randAluOp();
		case ($urandom % 6)
			0: return opAdd;
			1: return opRsub;
			2: return opOr;
			3: return opAnd;
			4: return opXor;
			default: return opAndn;
		endcase
	endfunction

	task automatic runTests();
		regIdxT prev;
		regIdxT rd;
		wordT v;
		// Any register, r0 included
		for (int i = 0; i < nRand; i++) begin
			if ($urandom % 2 == 0) begin
				issue("alu", randAluOp(), 5'($urandom), 5'($urandom), {5'($urandom), 11'h000});
			end else begin
				aluImm("alu", randAluOp(), 5'($urandom), 5'($urandom), 16'($urandom));
			end
		end
		prev = 5'd1;
		for (int i = 0; i < nChain; i++) begin
			rd = 5'(1 + $urandom % 3); // Each op reads the last result
			if (i % 2 == 0) begin
				issue("chain", randAluOp(), rd, prev, {prev, 11'h000});
			end else begin
				aluImm("chain", randAluOp(), rd, prev, 16'($urandom));
			end
			prev = rd;
		end
		for (int i = 0; i < nImm; i++) begin
			issue("imm", opImm, 5'd0, 5'd0, 16'($urandom));
			aluImm("imm", randAluOp(), 5'(1 + $urandom % 31), 5'($urandom), 16'($urandom));
			aluImm("imm", randAluOp(), 5'(1 + $urandom % 31), 5'($urandom),
				{i[0], 15'($urandom)}); // Sign extended, half negative
		end
		for (int i = 0; i < nBranch; i++) begin
			case (i % 3)
				0: v = '0;
				1: v = {1'b1, 31'($urandom)};
				default: v = {1'b0, 31'($urandom)} | 32'd1;
			endcase
			loadReg("branch", 5'd7, v);
			for (int c = 0; c < 8; c++) begin
				issue("branch", (c % 2 == 0) ? opBcci : opBcc, {2'($urandom), 3'(c)}, 5'd7,
					16'($urandom));
			end
		end
		for (int i = 0; i < nShift; i++) begin
			loadReg("shift", 5'd5, {1'b1, 31'($urandom)}); // Negative operand
			issue("shift", opShift, 5'd6, 5'd5, shiftSra);
			issue("shift", opShift, 5'd8, 5'd5, shiftSrl);
		end
	endtask

	initial begin
		void'($urandom(49));
		nrst = 1'b0;
		instrValid = 1'b0;
		instrWord = '0;
		resReady = 1'b0;
		modelImmPend = 1'b0;
		modelImmHi = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		repeat (4) @(posedge nclk);
		#1;
		nrst = 1'b1;
		runTests();
		while (expQ.size() != 0) begin
			@(posedge nclk);
		end
		repeat (20) @(posedge nclk); // Window for stray records
		if (gotCount != expCount) begin
			$display("Record count wrong: received %0d, expected %0d", gotCount, expCount);
			countErr = 1;
		end
		$display("Errors: %0d mismatches, %0d other", mismatches, otherErrs + countErr);
		if (mismatches == 0 && otherErrs + countErr == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Back-pressure, low about 30 percent
	always @(posedge nclk) begin
		#1;
		resReady = ($urandom % 10) >= 3;
	end

	// Retire monitor, mid-cycle where the handshake is stable
	always @(negedge nclk) begin
		if (nrst && resValid && resReady) begin
			gotCount++;
			if (expQ.size() == 0) begin
				$display("Unexpected record from the DUT: rd %0d data %h", resRd, resData);
				otherErrs++;
			end else begin
				expHead = expQ.pop_front();
				expName = nameQ.pop_front();
				if (resIsBranch !== expHead.isBranch) begin
					$display("Mismatch %s: expected isBranch %b, actual isBranch %b", expName,
						expHead.isBranch, resIsBranch);
					mismatches++;
				end else if (expHead.isBranch) begin
					checkBranch(expName, expHead.data, resData, expHead.taken, resTaken);
				end else begin
					checkWrite(expName, expHead.rd, resRd, expHead.data, resData);
				end
			end
		end
	end

	always @(posedge nclk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles with %0d expected records never received",
				cycles, expQ.size());
			$display("Errors: %0d mismatches, %0d other", mismatches, otherErrs + 1);
			$display("sim failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen #(
	parameter int halfPeriod = 4 // 8 ns period
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #halfPeriod clk_o = ~clk_o; // Free running
	end

endmodule

`default_nettype wire
